//--- hw/dcache_lookup_top.sv
`include "dcache_params.svh"

module dcache_lookup_top import dcache_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,

	input  addr_req_t                 rd_req_i,
	input  logic                      rd_valid_i,
	output logic                      rd_ready_o,

	input  addr_req_t                 wr_req_i,
	input  logic                      wr_valid_i,
	output logic                      wr_ready_o,

	// Tag memory
	output logic [`DC_ADDR_WIDTH-1:0] mem_addr_o,
	output logic                      mem_valid_o,
	input  logic                      mem_ready_i,
	input  logic                      mem_rvalid_i,
	input  tag_word_t                 mem_rdata_i,

	output logic                      result_valid_o,
	output lookup_result_t            result_o
);

logic       tq_push;
tag_entry_t tq_entry;
logic       tq_afull;
tag_entry_t tq_head;
logic       tq_empty;
logic       tq_pop;

index_extractor u_extractor (
	.clk         (clk),
	.rst_n       (rst_n),
	.rd_req_i    (rd_req_i),
	.rd_valid_i  (rd_valid_i),
	.rd_ready_o  (rd_ready_o),
	.wr_req_i    (wr_req_i),
	.wr_valid_i  (wr_valid_i),
	.wr_ready_o  (wr_ready_o),
	.mem_addr_o  (mem_addr_o),
	.mem_valid_o (mem_valid_o),
	.mem_ready_i (mem_ready_i),
	.tq_afull_i  (tq_afull),
	.tq_push_o   (tq_push),
	.tq_entry_o  (tq_entry)
);

tag_fifo u_tag_fifo (
	.clk     (clk),
	.rst_n   (rst_n),
	.push_i  (tq_push),
	.entry_i (tq_entry),
	.pop_i   (tq_pop),
	.head_o  (tq_head),
	.empty_o (tq_empty),
	.afull_o (tq_afull)
);

tag_checker u_checker (
	.clk            (clk),
	.rst_n          (rst_n),
	.rvalid_i       (mem_rvalid_i),
	.rdata_i        (mem_rdata_i),
	.head_i         (tq_head),
	.empty_i        (tq_empty),
	.pop_o          (tq_pop),
	.result_valid_o (result_valid_o),
	.result_o       (result_o)
);

endmodule

//--- hw/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Address split
////////////////////////////////////////////////////////////////////////////

// Processor byte address
`define DC_ADDR_WIDTH   32

`define DC_OFFSET_WIDTH 6   // 64 byte lines
`define DC_INDEX_WIDTH  8   // 256 sets

// Whatever is left above the index
`define DC_TAG_WIDTH    (`DC_ADDR_WIDTH - `DC_INDEX_WIDTH - `DC_OFFSET_WIDTH)

////////////////////////////////////////////////////////////////////////////
// Transaction ids and tag queue
////////////////////////////////////////////////////////////////////////////

`define DC_TID_WIDTH    8

// Entries in flight between tag read and tag return
`define DC_TQ_DEPTH     8

// Leaves room for the request already in the extractor
`define DC_TQ_AFULL     6

`endif

//--- hw/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [`DC_ADDR_WIDTH-1:0] addr;
	} addr_req_t;

	// One outstanding tag lookup
	typedef struct packed {
		logic                      is_write;
		logic [`DC_TID_WIDTH-1:0]  tid;      // 0 for writes
		logic [`DC_ADDR_WIDTH-1:0] addr;     // Full address, tag compared later
	} tag_entry_t;

	////////////////////////////////////////////////////////////////////////////
	// Tag memory and result side
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                     valid;
		logic [`DC_TAG_WIDTH-1:0] tag;
	} tag_word_t;

	typedef struct packed {
		logic                      is_write;
		logic [`DC_TID_WIDTH-1:0]  tid;
		logic [`DC_ADDR_WIDTH-1:0] addr;
		logic                      hit;
	} lookup_result_t;

	// Extractor FSM
	typedef enum logic [2:0] {
		IDLE,
		RD_ISSUE,   // Waiting for tag memory to take a read index
		RD_DONE,
		WR_ISSUE,   // Same for a write index
		WR_DONE
	} ext_state_e;

endpackage

//--- hw/index_extractor.sv
`include "dcache_params.svh"

module index_extractor import dcache_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,

	input  addr_req_t                 rd_req_i,
	input  logic                      rd_valid_i,
	output logic                      rd_ready_o,

	input  addr_req_t                 wr_req_i,
	input  logic                      wr_valid_i,
	output logic                      wr_ready_o,

	output logic [`DC_ADDR_WIDTH-1:0] mem_addr_o,
	output logic                      mem_valid_o,
	input  logic                      mem_ready_i,

	input  logic                      tq_afull_i,
	output logic                      tq_push_o,
	output tag_entry_t                tq_entry_o
);

localparam int IDX_LO = `DC_OFFSET_WIDTH;
localparam int IDX_HI = `DC_OFFSET_WIDTH + `DC_INDEX_WIDTH - 1;

ext_state_e                state, state_n;
logic                      prio_wr, prio_wr_n;      // Write wins the next tie
logic [`DC_TID_WIDTH-1:0]  tid_cnt, tid_cnt_n;
logic                      rdy_q, rdy_n;            // Shared by both channels
logic                      mem_valid_q, mem_valid_n;
logic                      push_q, push_n;
logic [`DC_ADDR_WIDTH-1:0] mem_addr_q, mem_addr_n;
tag_entry_t                entry_q, entry_n;
logic                      rd_fire, wr_fire;

// Keep only the set index, tag and offset cleared
function automatic logic [`DC_ADDR_WIDTH-1:0] index_only(input logic [`DC_ADDR_WIDTH-1:0] a);
	logic [`DC_ADDR_WIDTH-1:0] r;
	r = '0;
	r[IDX_HI:IDX_LO] = a[IDX_HI:IDX_LO];
	return r;
endfunction

////////////////////////////////////////////////////////////////////////////
// Handshake
////////////////////////////////////////////////////////////////////////////

// The loser of a tie never sees ready, so valid & ready is a real transfer
assign rd_ready_o = rdy_q & ~tq_afull_i & ~(wr_valid_i & prio_wr);
assign wr_ready_o = rdy_q & ~tq_afull_i & ~(rd_valid_i & ~prio_wr);

assign rd_fire = rd_valid_i & rd_ready_o;
assign wr_fire = wr_valid_i & wr_ready_o;

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state       <= IDLE;
		prio_wr     <= 1'b0;
		tid_cnt     <= `DC_TID_WIDTH'(1);
		rdy_q       <= 1'b1;
		mem_valid_q <= 1'b0;
		push_q      <= 1'b0;
	end else begin
		state       <= state_n;
		prio_wr     <= prio_wr_n;
		tid_cnt     <= tid_cnt_n;
		rdy_q       <= rdy_n;
		mem_valid_q <= mem_valid_n;
		push_q      <= push_n;
	end
end

always_ff @(posedge clk) begin
	mem_addr_q <= mem_addr_n;
	entry_q    <= entry_n;
end

////////////////////////////////////////////////////////////////////////////
// FSM
////////////////////////////////////////////////////////////////////////////

always_comb begin
	state_n     = state;
	prio_wr_n   = prio_wr;
	tid_cnt_n   = tid_cnt;
	rdy_n       = rdy_q;
	mem_valid_n = mem_valid_q;
	push_n      = push_q;
	mem_addr_n  = mem_addr_q;
	entry_n     = entry_q;

	case (state)
		IDLE: begin
			if (rd_fire) begin
				mem_addr_n       = index_only(rd_req_i.addr);
				entry_n.is_write = 1'b0;
				entry_n.tid      = tid_cnt;
				entry_n.addr     = rd_req_i.addr;
				tid_cnt_n        = tid_cnt + 1'b1;   // Wraps
				prio_wr_n        = 1'b1;
				rdy_n            = 1'b0;
				mem_valid_n      = 1'b1;
				state_n          = RD_ISSUE;
			end else if (wr_fire) begin
				mem_addr_n       = index_only(wr_req_i.addr);
				entry_n.is_write = 1'b1;
				entry_n.tid      = '0;
				entry_n.addr     = wr_req_i.addr;
				prio_wr_n        = 1'b0;
				rdy_n            = 1'b0;
				mem_valid_n      = 1'b1;
				state_n          = WR_ISSUE;
			end
		end
		RD_ISSUE: begin
			if (mem_ready_i) begin
				mem_valid_n = 1'b0;
				push_n      = 1'b1;
				state_n     = RD_DONE;
			end
		end
		WR_ISSUE: begin
			if (mem_ready_i) begin
				mem_valid_n = 1'b0;
				push_n      = 1'b1;
				state_n     = WR_DONE;
			end
		end
		RD_DONE, WR_DONE: begin
			push_n  = 1'b0;
			rdy_n   = 1'b1;
			state_n = IDLE;
		end
		default: state_n = IDLE;
	endcase
end

assign mem_addr_o  = mem_addr_q;
assign mem_valid_o = mem_valid_q;
assign tq_push_o   = push_q;
assign tq_entry_o  = entry_q;

endmodule

//--- hw/tag_checker.sv
`include "dcache_params.svh"

module tag_checker import dcache_pkg::*; (
	input  logic           clk,
	input  logic           rst_n,

	// Tag memory return, in request order
	input  logic           rvalid_i,
	input  tag_word_t      rdata_i,

	input  tag_entry_t     head_i,
	input  logic           empty_i,
	output logic           pop_o,

	output logic           result_valid_o,
	output lookup_result_t result_o
);

localparam int TAG_LO = `DC_OFFSET_WIDTH + `DC_INDEX_WIDTH;

logic [`DC_TAG_WIDTH-1:0] head_tag;
logic                     hit;
logic                     res_valid_q;
lookup_result_t           res_q;

////////////////////////////////////////////////////////////////////////////
// Compare
////////////////////////////////////////////////////////////////////////////

assign head_tag = head_i.addr[`DC_ADDR_WIDTH-1:TAG_LO];
assign hit      = rdata_i.valid & (rdata_i.tag == head_tag);

// Each return consumes the oldest outstanding lookup
assign pop_o = rvalid_i & ~empty_i;

////////////////////////////////////////////////////////////////////////////
// Result register
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	if (!rst_n)
		res_valid_q <= 1'b0;
	else
		res_valid_q <= pop_o;
end

always_ff @(posedge clk) begin
	if (pop_o) begin
		res_q.is_write <= head_i.is_write;
		res_q.tid      <= head_i.tid;
		res_q.addr     <= head_i.addr;
		res_q.hit      <= hit;
	end
end

assign result_valid_o = res_valid_q;
assign result_o       = res_q;

endmodule

//--- hw/tag_fifo.sv
`include "dcache_params.svh"

module tag_fifo import dcache_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,

	input  logic       push_i,
	input  tag_entry_t entry_i,

	input  logic       pop_i,
	output tag_entry_t head_o,

	output logic       empty_o,
	output logic       afull_o
);

localparam int DEPTH = `DC_TQ_DEPTH;
localparam int PTR_W = $clog2(DEPTH);
localparam int CNT_W = $clog2(DEPTH + 1);

tag_entry_t       mem [DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic             do_push, do_pop;

// Push into a full queue and pop from an empty one are dropped
assign do_push = push_i & (count != CNT_W'(DEPTH));
assign do_pop  = pop_i & (count != '0);

////////////////////////////////////////////////////////////////////////////
// Storage
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	if (do_push)
		mem[wr_ptr] <= entry_i;
end

////////////////////////////////////////////////////////////////////////////
// Pointers and occupancy
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	if (!rst_n) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end else begin
		if (do_push)
			wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
		if (do_pop)
			rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

		case ({do_push, do_pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;   // Both or neither
		endcase
	end
end

assign head_o  = mem[rd_ptr];
assign empty_o = (count == '0);
assign afull_o = (count >= CNT_W'(`DC_TQ_AFULL));

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the lookup testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f sources.f --top-module tb_dcache_lookup -o tb_sim \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation did not run"; exit 1; }
cat sim.log

grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "No pass line in log"; exit 1; }
exit 0

//--- sim/tag_mem_model.sv
`include "dcache_params.svh"

module tag_mem_model import dcache_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,

	input  logic [`DC_ADDR_WIDTH-1:0] mem_addr_i,
	input  logic                      mem_valid_i,
	output logic                      mem_ready_o,

	output logic                      mem_rvalid_o,
	output tag_word_t                 mem_rdata_o,

	input  logic                      stall_i      // Rising edge holds returns 40 cycles
);

localparam int IDX_LO = `DC_OFFSET_WIDTH;
localparam int IDX_HI = `DC_OFFSET_WIDTH + `DC_INDEX_WIDTH - 1;

integer                    seed;
int                        cycle;
int                        accept_wait;
int                        hold_until;
logic                      stall_q;
logic [`DC_ADDR_WIDTH-1:0] pend_addr[$];
int                        pend_due[$];

// Even sets are valid with a tag of five times the set index
function automatic tag_word_t stored_word(input logic [`DC_INDEX_WIDTH-1:0] k);
	tag_word_t w;
	w.valid = ~k[0];
	w.tag   = `DC_TAG_WIDTH'(k * 5);
	return w;
endfunction

initial begin
	seed         = 32'h2536_3ca4;
	cycle        = 0;
	hold_until   = 0;
	stall_q      = 1'b0;
	mem_ready_o  = 1'b0;
	mem_rvalid_o = 1'b0;
	mem_rdata_o  = '0;
	accept_wait  = $unsigned($random(seed)) % 4;
end

////////////////////////////////////////////////////////////////////////////
// Inputs sampled on the rising edge
////////////////////////////////////////////////////////////////////////////

always @(posedge clk) begin
	cycle = cycle + 1;
	if (stall_i && !stall_q)
		hold_until = cycle + 40;
	stall_q = stall_i;

	if (rst_n && mem_valid_i && mem_ready_o) begin
		pend_addr.push_back(mem_addr_i);
		// Entry is queued one edge after acceptance and returns 1 to 4 cycles after it
		pend_due.push_back(cycle + 1 + ($unsigned($random(seed)) % 4));
		accept_wait = $unsigned($random(seed)) % 4;
	end
end

////////////////////////////////////////////////////////////////////////////
// Outputs change on the falling edge
////////////////////////////////////////////////////////////////////////////

always @(negedge clk) begin
	if (!rst_n || !mem_valid_i) begin
		mem_ready_o = 1'b0;
	end else if (accept_wait > 0) begin
		accept_wait = accept_wait - 1;
		mem_ready_o = 1'b0;
	end else begin
		mem_ready_o = 1'b1;
	end

	mem_rvalid_o = 1'b0;
	if (rst_n && cycle >= hold_until && pend_due.size() > 0 && pend_due[0] <= cycle) begin
		mem_rvalid_o = 1'b1;
		mem_rdata_o  = stored_word(pend_addr[0][IDX_HI:IDX_LO]);
		void'(pend_addr.pop_front());
		void'(pend_due.pop_front());
	end
end

endmodule

//--- sim/tb_dcache_lookup.sv
`include "dcache_params.svh"

module tb_dcache_lookup import dcache_pkg::*; ();

localparam int NROWS      = 15;
localparam int CLK_PERIOD = 4;
localparam int AW         = `DC_ADDR_WIDTH;

logic           clk;
logic           rst_n;
addr_req_t      rd_req, wr_req;
logic           rd_valid, rd_ready, wr_valid, wr_ready;
logic [AW-1:0]  mem_addr;
logic           mem_valid, mem_ready, mem_rvalid;
tag_word_t      mem_rdata;
logic           result_valid;
lookup_result_t result;
logic           stall;

// Stimulus table. Bit 0 of sel raises read valid and bit 1 write valid
logic [AW-1:0]  tbl_rd[NROWS];
logic [AW-1:0]  tbl_wr[NROWS];
logic [1:0]     tbl_sel[NROWS];
logic           tbl_stall[NROWS];

lookup_result_t exp_res_q[$];
int             exp_row_q[$];
logic           exp_last_q[$];
logic [AW-1:0]  exp_mem_q[$];

integer                   seed;
int                       errors, checks, accepted, results, max_out;
logic                     rd_taken, wr_taken;
logic                     prio_wr;
logic [`DC_TID_WIDTH-1:0] next_tid;

dcache_lookup_top DUT (
	.clk            (clk),
	.rst_n          (rst_n),
	.rd_req_i       (rd_req),
	.rd_valid_i     (rd_valid),
	.rd_ready_o     (rd_ready),
	.wr_req_i       (wr_req),
	.wr_valid_i     (wr_valid),
	.wr_ready_o     (wr_ready),
	.mem_addr_o     (mem_addr),
	.mem_valid_o    (mem_valid),
	.mem_ready_i    (mem_ready),
	.mem_rvalid_i   (mem_rvalid),
	.mem_rdata_i    (mem_rdata),
	.result_valid_o (result_valid),
	.result_o       (result)
);

tag_mem_model u_mem (
	.clk          (clk),
	.rst_n        (rst_n),
	.mem_addr_i   (mem_addr),
	.mem_valid_i  (mem_valid),
	.mem_ready_o  (mem_ready),
	.mem_rvalid_o (mem_rvalid),
	.mem_rdata_o  (mem_rdata),
	.stall_i      (stall)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
	#(NROWS * 200 * CLK_PERIOD);
	$display("Timeout, run did not finish within %0d cycles", NROWS * 200);
	$display("ERRORS FOUND");
	$finish;
end

////////////////////////////////////////////////////////////////////////////
// Reference rules
////////////////////////////////////////////////////////////////////////////

function automatic logic [AW-1:0] addr_of(input int tag, input int idx, input int off);
	return {`DC_TAG_WIDTH'(tag), `DC_INDEX_WIDTH'(idx), `DC_OFFSET_WIDTH'(off)};
endfunction

function automatic logic predict_hit(input logic [AW-1:0] a);
	int k;
	int tag;
	k   = (a >> `DC_OFFSET_WIDTH) % (1 << `DC_INDEX_WIDTH);
	tag = a >> (`DC_OFFSET_WIDTH + `DC_INDEX_WIDTH);
	return (k % 2 == 0) && (tag == (k * 5) % (1 << `DC_TAG_WIDTH));
endfunction

function automatic logic [AW-1:0] expected_mem_addr(input logic [AW-1:0] a);
	logic [AW-1:0] mask;
	mask = ((AW'(1) << `DC_INDEX_WIDTH) - 1) << `DC_OFFSET_WIDTH;
	return a & mask;
endfunction

task automatic expect_lookup(input logic wr, input logic [AW-1:0] a, input int row,
		input logic last);
	lookup_result_t e;
	e.is_write = wr;
	e.tid      = wr ? '0 : next_tid;
	e.addr     = a;
	e.hit      = predict_hit(a);
	if (!wr)
		next_tid = next_tid + 1'b1;
	prio_wr = ~wr;   // Each grant favors the other channel next
	exp_res_q.push_back(e);
	exp_row_q.push_back(row);
	exp_last_q.push_back(last);
	exp_mem_q.push_back(expected_mem_addr(a));
endtask

task automatic load_table();
	for (int r = 0; r < NROWS; r++) begin
		tbl_rd[r]    = addr_of(r * 3 + 1, 2 * r + 1, $random(seed));
		tbl_wr[r]    = addr_of(r * 7 + 2, 2 * r + 1, $random(seed));
		tbl_sel[r]   = 2'b11;
		tbl_stall[r] = (r >= 7 && r <= 12);
	end
	tbl_rd[0] = addr_of(20, 4, 3);     tbl_sel[0] = 2'b01;    // Hit
	tbl_rd[1] = addr_of(35, 7, 9);     tbl_sel[1] = 2'b01;    // Odd set
	tbl_wr[2] = addr_of(50, 10, 0);    tbl_sel[2] = 2'b10;
	tbl_wr[3] = addr_of(99, 12, 63);   tbl_sel[3] = 2'b10;    // Tag differs
	tbl_rd[4] = addr_of(40, 8, 1);     tbl_sel[4] = 2'b01;
	tbl_rd[5] = addr_of(1, 3, 2);
	tbl_wr[5] = addr_of(80, 16, 5);
	tbl_rd[6] = addr_of(30, 6, 7);
	tbl_wr[6] = addr_of(45, 9, 4);
	for (int r = 7; r <= 12; r++)
		tbl_rd[r] = addr_of(r * 20, r * 4, r);                // Even sets that hit
	tbl_wr[13] = addr_of(100, 20, 11); tbl_sel[13] = 2'b10;
	tbl_wr[14] = addr_of(60, 13, 8);                          // Tie right after a write
endtask

////////////////////////////////////////////////////////////////////////////
// Drive and monitor
////////////////////////////////////////////////////////////////////////////

task automatic apply_row(input int r);
	if (tbl_sel[r] == 2'b01) begin
		expect_lookup(1'b0, tbl_rd[r], r, 1'b1);
	end else if (tbl_sel[r] == 2'b10) begin
		expect_lookup(1'b1, tbl_wr[r], r, 1'b1);
	end else if (!prio_wr) begin
		expect_lookup(1'b0, tbl_rd[r], r, 1'b0);
		expect_lookup(1'b1, tbl_wr[r], r, 1'b1);
	end else begin
		expect_lookup(1'b1, tbl_wr[r], r, 1'b0);
		expect_lookup(1'b0, tbl_rd[r], r, 1'b1);
	end
	stall       = tbl_stall[r];
	rd_req.addr = tbl_rd[r];
	wr_req.addr = tbl_wr[r];
	rd_taken    = 1'b0;
	wr_taken    = 1'b0;
	rd_valid    = tbl_sel[r][0];
	wr_valid    = tbl_sel[r][1];
	while (rd_valid || wr_valid) begin
		@(negedge clk);
		if (rd_taken)
			rd_valid = 1'b0;
		if (wr_taken)
			wr_valid = 1'b0;
	end
endtask

task automatic check_idle_outputs();
	checks++;
	if (rd_ready !== 1'b1 || wr_ready !== 1'b1 || mem_valid !== 1'b0
			|| result_valid !== 1'b0) begin
		errors++;
		$display("MISMATCH idle outputs rd_ready_o=%h wr_ready_o=%h mem_valid_o=%h result_valid_o=%h",
			rd_ready, wr_ready, mem_valid, result_valid);
	end
endtask

task automatic check_result();
	lookup_result_t e;
	int row;
	logic last;
	checks++;
	results++;
	if (exp_res_q.size() == 0) begin
		errors++;
		$display("Result arrived with no lookup outstanding");
	end else begin
		e    = exp_res_q.pop_front();
		row  = exp_row_q.pop_front();
		last = exp_last_q.pop_front();
		if (result !== e) begin
			errors++;
			$display("MISMATCH result_o got %h expected %h (row %0d)", result, e, row);
		end
		if (last)
			$display("Row %0d done, errors so far %0d", row, errors);
	end
endtask

always @(posedge clk) begin
	if (rst_n) begin
		if (result_valid)
			check_result();
		if ((rd_valid && rd_ready) || (wr_valid && wr_ready)) begin
			rd_taken = rd_taken | (rd_valid & rd_ready);
			wr_taken = wr_taken | (wr_valid & wr_ready);
			accepted++;
			if (accepted - results > 6) begin
				errors++;
				$display("Request accepted with %0d lookups already queued",
					accepted - results - 1);
			end
			if (accepted - results > max_out)
				max_out = accepted - results;
		end
		if (mem_valid && mem_ready) begin
			checks++;
			if (exp_mem_q.size() == 0) begin
				errors++;
				$display("Tag read issued with no request accepted");
			end else if (mem_addr !== exp_mem_q[0]) begin
				errors++;
				$display("MISMATCH mem_addr_o got %h expected %h", mem_addr, exp_mem_q[0]);
			end
			if (exp_mem_q.size() != 0)
				void'(exp_mem_q.pop_front());
		end
	end
end

initial begin
	seed        = 32'h2536_3ca4;
	errors      = 0;
	checks      = 0;
	accepted    = 0;
	results     = 0;
	max_out     = 0;
	prio_wr     = 1'b0;
	next_tid    = `DC_TID_WIDTH'(1);
	rd_taken    = 1'b0;
	wr_taken    = 1'b0;
	rst_n       = 1'b0;
	rd_req.addr = '0;
	wr_req.addr = '0;
	rd_valid    = 1'b0;
	wr_valid    = 1'b0;
	stall       = 1'b0;
	load_table();

	for (int i = 0; i < 16; i++) begin
		@(negedge clk);
		check_idle_outputs();
	end
	rst_n = 1'b1;
	@(negedge clk);
	check_idle_outputs();

	for (int r = 0; r < NROWS; r++)
		apply_row(r);
	stall = 1'b0;

	while (exp_res_q.size() != 0)
		@(negedge clk);
	repeat (4) @(negedge clk);

	// Stall rows must have filled the queue up to the almost-full point
	if (max_out != 6) begin
		errors++;
		$display("Back-pressure not seen, peak of %0d lookups outstanding", max_out);
	end

	$display("Rows %0d, checks %0d, results %0d, errors %0d", NROWS, checks, results, errors);
	if (errors == 0)
		$display("NO ERRORS");
	else
		$display("ERRORS FOUND");
	$finish;
end

endmodule

//--- sources.f
+incdir+hw
hw/dcache_pkg.sv
hw/index_extractor.sv
hw/tag_fifo.sv
hw/tag_checker.sv
hw/dcache_lookup_top.sv
sim/tag_mem_model.sv
sim/tb_dcache_lookup.sv
